/* src/tempo_pkg.sv */
package tempo_pkg;

	// tempo as read from the switch word, one to 255 is the usable range
	typedef logic [7:0] tempo_t;

	// tempo loaded by reset, one step every four cycles with the test threshold
	localparam tempo_t TEMPO_RESET = 8'd60;

	// smallest tempo the panel will load; a zero word would stall the beat clock
	localparam tempo_t TEMPO_MIN = 8'd1;

endpackage

/* src/seq_pkg.sv */
package seq_pkg;

	localparam int NUM_STEPS = 8; // steps per bar
	localparam int NUM_VOICES = 4; // instrument patterns held by the datapath

	typedef logic [$clog2(NUM_STEPS)-1:0] step_t;

	// one bit per step, bit n fires the voice on step n
	typedef logic [NUM_STEPS-1:0] pattern_t;

	typedef enum logic [1:0] {
		MODE_PLAY       = 2'd0,
		MODE_EDIT_VOICE = 2'd1,
		MODE_EDIT_TEMPO = 2'd2
	} mode_e;

	typedef enum logic [1:0] {
		TARGET_VOICE1 = 2'd0,
		TARGET_VOICE2 = 2'd1,
		TARGET_VOICE3 = 2'd2,
		TARGET_VOICE4 = 2'd3
	} target_e;

	// the switch word is read as a pattern in edit voice and as a tempo in edit tempo
	typedef union packed {
		pattern_t pattern;
		tempo_pkg::tempo_t tempo;
	} panel_word_u;

endpackage

/* src/panel_control.sv */
`timescale 1ns/10ps

module panel_control (
	input logic clk,
	input logic reset,
	input logic btn_mode, // single-cycle pulses from the front panel
	input logic btn_next,
	input logic btn_enter,
	input seq_pkg::panel_word_u sel,
	output logic ld_ins1,
	output logic ld_ins2,
	output logic ld_ins3,
	output logic ld_ins4,
	output logic ld_bpm,
	output logic play,
	output seq_pkg::mode_e mode,
	output seq_pkg::target_e target
);

	seq_pkg::mode_e next_mode;
	seq_pkg::target_e next_target;
	logic tempo_ok;
	logic enter_voice;
	logic enter_tempo;

	// mode cycle is play, edit voice, edit tempo and back to play
	always_comb begin
		case (mode)
			seq_pkg::MODE_PLAY: next_mode = seq_pkg::MODE_EDIT_VOICE;
			seq_pkg::MODE_EDIT_VOICE: next_mode = seq_pkg::MODE_EDIT_TEMPO;
			default: next_mode = seq_pkg::MODE_PLAY;
		endcase
	end

	// voice selection wraps from four back to one
	always_comb begin
		case (target)
			seq_pkg::TARGET_VOICE1: next_target = seq_pkg::TARGET_VOICE2;
			seq_pkg::TARGET_VOICE2: next_target = seq_pkg::TARGET_VOICE3;
			seq_pkg::TARGET_VOICE3: next_target = seq_pkg::TARGET_VOICE4;
			default: next_target = seq_pkg::TARGET_VOICE1;
		endcase
	end

	assign tempo_ok = sel.tempo >= tempo_pkg::TEMPO_MIN; // a zero word is not a tempo

	// btn_mode wins over btn_enter in the same cycle, so no load follows a mode change
	assign enter_voice = btn_enter && !btn_mode && (mode == seq_pkg::MODE_EDIT_VOICE);
	assign enter_tempo = btn_enter && !btn_mode && (mode == seq_pkg::MODE_EDIT_TEMPO);

	always_ff @(posedge clk) begin
		if (!reset) begin
			mode <= seq_pkg::MODE_PLAY;
			play <= 1'b0; // the panel comes up stopped
		end else if (btn_mode) begin
			mode <= next_mode;
			play <= 1'b0; // leaving play stops the bar, entering play waits for enter
		end else if (mode == seq_pkg::MODE_PLAY && btn_enter) begin
			play <= !play; // enter starts and stops the sequence
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			target <= seq_pkg::TARGET_VOICE1;
		end else if (btn_next && !btn_mode && mode == seq_pkg::MODE_EDIT_VOICE) begin
			target <= next_target;
		end
	end

	// strobes last one cycle since they are rebuilt from the button pulse every clock
	always_ff @(posedge clk) begin
		if (!reset) begin
			ld_ins1 <= 1'b0;
			ld_ins2 <= 1'b0;
			ld_ins3 <= 1'b0;
			ld_ins4 <= 1'b0;
			ld_bpm <= 1'b0;
		end else begin
			ld_ins1 <= enter_voice && (target == seq_pkg::TARGET_VOICE1);
			ld_ins2 <= enter_voice && (target == seq_pkg::TARGET_VOICE2);
			ld_ins3 <= enter_voice && (target == seq_pkg::TARGET_VOICE3);
			ld_ins4 <= enter_voice && (target == seq_pkg::TARGET_VOICE4);
			ld_bpm <= enter_tempo && tempo_ok;
		end
	end

endmodule

/* src/datapath.sv */
`timescale 1ns/10ps

module datapath (
	input logic clk,
	input logic reset,
	input seq_pkg::panel_word_u sel, // switch word, held by the panel while a strobe is high
	input logic ld_ins1,
	input logic ld_ins2,
	input logic ld_ins3,
	input logic ld_ins4,
	input logic ld_bpm,
	input logic play,
	input seq_pkg::step_t step, // current step from the beat clock
	output logic ins1_out,
	output logic ins2_out,
	output logic ins3_out,
	output logic ins4_out,
	output tempo_pkg::tempo_t bpm
);

	seq_pkg::pattern_t pattern [seq_pkg::NUM_VOICES];
	logic [seq_pkg::NUM_VOICES-1:0] ld_ins;
	logic [seq_pkg::NUM_VOICES-1:0] step_bits;

	assign ld_ins = {ld_ins4, ld_ins3, ld_ins2, ld_ins1}; // voice one in bit zero

	// pattern and tempo registers, loaded on the clock where the strobe is high
	always_ff @(posedge clk) begin
		if (!reset) begin
			for (int v = 0; v < seq_pkg::NUM_VOICES; v++) begin
				pattern[v] <= '0; // every voice starts silent
			end
			bpm <= tempo_pkg::TEMPO_RESET;
		end else begin
			for (int v = 0; v < seq_pkg::NUM_VOICES; v++) begin
				if (ld_ins[v]) begin
					pattern[v] <= sel.pattern;
				end
			end
			if (ld_bpm) begin
				bpm <= sel.tempo;
			end
		end
	end

	// pick the bit of every voice for the step the beat clock shows this cycle
	always_comb begin
		for (int v = 0; v < seq_pkg::NUM_VOICES; v++) begin
			step_bits[v] = pattern[v][step];
		end
	end

	// Triggers are registered, so they follow step by one cycle.
	// Stopping silences every voice on the next clock.
	always_ff @(posedge clk) begin
		if (!reset) begin
			ins1_out <= 1'b0;
			ins2_out <= 1'b0;
			ins3_out <= 1'b0;
			ins4_out <= 1'b0;
		end else if (play) begin
			ins1_out <= step_bits[0];
			ins2_out <= step_bits[1];
			ins3_out <= step_bits[2];
			ins4_out <= step_bits[3];
		end else begin
			ins1_out <= 1'b0; // not playing, all voices quiet
			ins2_out <= 1'b0;
			ins3_out <= 1'b0;
			ins4_out <= 1'b0;
		end
	end

endmodule

/* src/beat_clock.sv */
`timescale 1ns/10ps

module beat_clock #(
	parameter int unsigned STEP_THRESHOLD = 32'd12_000_000 // accumulator value per step
) (
	input logic clk,
	input logic reset,
	input logic play,
	input tempo_pkg::tempo_t bpm,
	output seq_pkg::step_t step,
	output logic step_pulse // high in the cycle the new step first shows
);

	// room for a leftover below the threshold plus one more tempo
	localparam int ACC_W = $clog2(STEP_THRESHOLD + 256);

	logic [ACC_W-1:0] acc;
	logic [ACC_W-1:0] acc_sum;
	logic step_due;

	assign acc_sum = acc + ACC_W'(bpm);
	assign step_due = acc_sum >= ACC_W'(STEP_THRESHOLD);

	// The remainder is carried over, so the interval alternates between
	// the floor and ceiling of threshold over tempo.
	always_ff @(posedge clk) begin
		if (!reset) begin
			acc <= '0;
			step <= '0;
			step_pulse <= 1'b0;
		end else if (!play) begin
			acc <= '0; // stopped, the next start begins on step zero
			step <= '0;
			step_pulse <= 1'b0;
		end else if (step_due) begin
			acc <= acc_sum - ACC_W'(STEP_THRESHOLD);
			if (step == seq_pkg::step_t'(seq_pkg::NUM_STEPS - 1)) begin
				step <= '0; // end of the bar
			end else begin
				step <= step + 1'b1;
			end
			step_pulse <= 1'b1;
		end else begin
			acc <= acc_sum;
			step_pulse <= 1'b0;
		end
	end

endmodule

/* src/drum_machine.sv */
`timescale 1ns/10ps

module drum_machine #(
	parameter int unsigned STEP_THRESHOLD = 32'd12_000_000 // set low by the testbench
) (
	input logic clk,
	input logic reset,
	input logic btn_mode,
	input logic btn_next,
	input logic btn_enter,
	input seq_pkg::panel_word_u sel,
	output logic ins1_out,
	output logic ins2_out,
	output logic ins3_out,
	output logic ins4_out,
	output seq_pkg::step_t step,
	output logic step_pulse,
	output seq_pkg::mode_e mode,
	output seq_pkg::target_e target
);

	logic ld_ins1;
	logic ld_ins2;
	logic ld_ins3;
	logic ld_ins4;
	logic ld_bpm;
	logic play; // run level from the panel
	tempo_pkg::tempo_t bpm; // stored tempo feeding the beat clock

	panel_control u_panel_control (
		.clk       (clk),
		.reset     (reset),
		.btn_mode  (btn_mode),
		.btn_next  (btn_next),
		.btn_enter (btn_enter),
		.sel       (sel),
		.ld_ins1   (ld_ins1),
		.ld_ins2   (ld_ins2),
		.ld_ins3   (ld_ins3),
		.ld_ins4   (ld_ins4),
		.ld_bpm    (ld_bpm),
		.play      (play),
		.mode      (mode),
		.target    (target)
	);

	datapath u_datapath (
		.clk      (clk),
		.reset    (reset),
		.sel      (sel),
		.ld_ins1  (ld_ins1),
		.ld_ins2  (ld_ins2),
		.ld_ins3  (ld_ins3),
		.ld_ins4  (ld_ins4),
		.ld_bpm   (ld_bpm),
		.play     (play),
		.step     (step),
		.ins1_out (ins1_out),
		.ins2_out (ins2_out),
		.ins3_out (ins3_out),
		.ins4_out (ins4_out),
		.bpm      (bpm)
	);

	beat_clock #(
		.STEP_THRESHOLD (STEP_THRESHOLD)
	) u_beat_clock (
		.clk        (clk),
		.reset      (reset),
		.play       (play),
		.bpm        (bpm),
		.step       (step),
		.step_pulse (step_pulse)
	);

endmodule

/* tb/drum_machine_assertions.sv */
`timescale 1ns/10ps

module drum_machine_assertions (
	input logic clk,
	input logic reset,
	input logic play,
	input logic ld_ins1,
	input logic ld_ins2,
	input logic ld_ins3,
	input logic ld_ins4,
	input logic ld_bpm,
	input seq_pkg::step_t step,
	input logic step_pulse,
	input logic ins1_out,
	input logic ins2_out,
	input logic ins3_out,
	input logic ins4_out,
	input seq_pkg::mode_e mode
);

	logic [4:0] strobes;
	logic [3:0] voices;
	int error_count = 0; // failed checks, watched by the testbench

	assign strobes = {ld_bpm, ld_ins4, ld_ins3, ld_ins2, ld_ins1};
	assign voices = {ins4_out, ins3_out, ins2_out, ins1_out};

	// every load strobe is a single-cycle pulse
	for (genvar i = 0; i < 5; i++) begin : g_strobe
		assert property (@(posedge clk) disable iff (!reset) strobes[i] |=> !strobes[i])
		else begin
			error_count++;
			$error("load strobe %0d stayed high for more than one cycle", i);
		end
	end

	assert property (@(posedge clk) disable iff (!reset) $onehot0(strobes))
	else begin
		error_count++;
		$error("more than one load strobe high in the same cycle");
	end

	// loads only happen from the edit modes, where the bar is stopped
	assert property (@(posedge clk) disable iff (!reset) (strobes != '0) |-> !play)
	else begin
		error_count++;
		$error("load strobe raised while playing");
	end

	assert property (@(posedge clk) disable iff (!reset) play |-> mode == seq_pkg::MODE_PLAY)
	else begin
		error_count++;
		$error("play level high outside play mode");
	end

	// while running, step moves by one and only together with the pulse
	assert property (@(posedge clk) disable iff (!reset)
		$past(play) && ($changed(step) || step_pulse) |->
			step_pulse && step == seq_pkg::step_t'($past(step) + 1'b1))
	else begin
		error_count++;
		$error("step changed from %0d to %0d without a single step pulse", $past(step), step);
	end

	// a stopped panel holds step at zero and silences every voice
	assert property (@(posedge clk) disable iff (!reset)
		!$past(play) |-> step == '0 && !step_pulse && voices == '0)
	else begin
		error_count++;
		$error("step, step pulse or voices active one cycle after play went low");
	end

endmodule

/* tb/drum_machine_tb.sv */
`timescale 1ns/10ps

module drum_machine_tb;

	localparam int unsigned THRESHOLD = 240;
	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 8;
	localparam logic [31:0] SEED = 32'ha3d6fe75;
	localparam int MIN_TEST_TEMPO = 16; // random tempos stay at or above this
	localparam int MAX_INTERVAL = (THRESHOLD + MIN_TEST_TEMPO - 1) / MIN_TEST_TEMPO;
	localparam int TOTAL_STEPS = (seq_pkg::NUM_STEPS + 1) + (3 * seq_pkg::NUM_STEPS + 1) +
		(seq_pkg::NUM_STEPS + 1);
	localparam int PANEL_CYCLES = 200; // button presses and idle gaps
	localparam int WATCHDOG_CYCLES = (TOTAL_STEPS * MAX_INTERVAL + PANEL_CYCLES) * 2;
	localparam int KEY_MODE = 0;
	localparam int KEY_NEXT = 1;
	localparam int KEY_ENTER = 2;

	logic clk;
	logic reset;
	logic btn_mode;
	logic btn_next;
	logic btn_enter;
	seq_pkg::panel_word_u sel;
	logic ins1_out;
	logic ins2_out;
	logic ins3_out;
	logic ins4_out;
	logic [3:0] ins_vec;
	seq_pkg::step_t step;
	logic step_pulse;
	seq_pkg::mode_e mode;
	seq_pkg::target_e target;

	// reference model, updated on the clock where the DUT samples a button
	seq_pkg::pattern_t model_pat [seq_pkg::NUM_VOICES] = '{default: '0};
	tempo_pkg::tempo_t model_tempo = tempo_pkg::TEMPO_RESET;
	seq_pkg::mode_e model_mode = seq_pkg::MODE_PLAY;
	seq_pkg::target_e model_target = seq_pkg::TARGET_VOICE1;
	logic model_play = 1'b0;
	int gap = 0; // cycles since the last step pulse
	logic pulse_seen = 1'b0;

	drum_machine #(
		.STEP_THRESHOLD (THRESHOLD)
	) UUT (
		.clk        (clk),
		.reset      (reset),
		.btn_mode   (btn_mode),
		.btn_next   (btn_next),
		.btn_enter  (btn_enter),
		.sel        (sel),
		.ins1_out   (ins1_out),
		.ins2_out   (ins2_out),
		.ins3_out   (ins3_out),
		.ins4_out   (ins4_out),
		.step       (step),
		.step_pulse (step_pulse),
		.mode       (mode),
		.target     (target)
	);

	bind drum_machine drum_machine_assertions u_assertions (
		.clk        (clk),
		.reset      (reset),
		.play       (play),
		.ld_ins1    (ld_ins1),
		.ld_ins2    (ld_ins2),
		.ld_ins3    (ld_ins3),
		.ld_ins4    (ld_ins4),
		.ld_bpm     (ld_bpm),
		.step       (step),
		.step_pulse (step_pulse),
		.ins1_out   (ins1_out),
		.ins2_out   (ins2_out),
		.ins3_out   (ins3_out),
		.ins4_out   (ins4_out),
		.mode       (mode)
	);

	assign ins_vec = {ins4_out, ins3_out, ins2_out, ins1_out};

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_error(input string msg);
		abort_run($sformatf("** Error at %0t ns: %s", $time, msg));
	endtask

	task automatic idle_cycles(input int count);
		repeat (count) @(posedge clk);
	endtask

	task automatic set_switches(input logic [7:0] value);
		@(posedge clk);
		sel <= value;
	endtask

	task automatic wait_steps(input int count);
		for (int i = 0; i < count; i++) begin
			do @(posedge clk); while (!step_pulse);
		end
	endtask

	// one-cycle press; the model follows on the edge where the DUT samples it
	task automatic press_button(input int key);
		@(posedge clk);
		case (key)
			KEY_MODE: btn_mode <= 1'b1;
			KEY_NEXT: btn_next <= 1'b1;
			default: btn_enter <= 1'b1;
		endcase
		@(posedge clk);
		btn_mode <= 1'b0;
		btn_next <= 1'b0;
		btn_enter <= 1'b0;
		if (key == KEY_MODE) begin
			model_play <= 1'b0;
			if (model_mode == seq_pkg::MODE_EDIT_TEMPO) begin
				model_mode <= seq_pkg::MODE_PLAY;
			end else begin
				model_mode <= seq_pkg::mode_e'(model_mode + 1);
			end
		end else if (key == KEY_NEXT && model_mode == seq_pkg::MODE_EDIT_VOICE) begin
			model_target <= seq_pkg::target_e'((int'(model_target) + 1) % seq_pkg::NUM_VOICES);
		end else if (key == KEY_ENTER) begin
			case (model_mode)
				seq_pkg::MODE_PLAY: model_play <= !model_play;
				seq_pkg::MODE_EDIT_VOICE: model_pat[model_target] <= sel.pattern;
				default: if (sel.tempo != '0) model_tempo <= sel.tempo; // zero is ignored
			endcase
		end
	endtask

	always @(posedge clk) begin
		if (!reset || !model_play) begin
			gap <= 0;
			pulse_seen <= 1'b0;
		end else if (step_pulse) begin
			gap <= 1;
			pulse_seen <= 1'b1;
		end else begin
			gap <= gap + 1;
		end
	end

	// each trigger is the pattern bit of the step shown one cycle earlier
	for (genvar v = 0; v < seq_pkg::NUM_VOICES; v++) begin : g_voice_check
		assert property (@(posedge clk) disable iff (!reset)
			ins_vec[v] == ($past(model_play) ? model_pat[v][$past(step)] : 1'b0))
		else report_error($sformatf("voice %0d trigger differs from its pattern", v + 1));
	end

	assert property (@(posedge clk) disable iff (!reset)
		step_pulse && model_play && pulse_seen |->
			gap >= THRESHOLD / int'(model_tempo) &&
			gap <= (THRESHOLD + int'(model_tempo) - 1) / int'(model_tempo))
	else report_error($sformatf("step interval %0d does not fit tempo %0d", gap, model_tempo));

	assert property (@(posedge clk) disable iff (!reset)
		!$past(model_play) |-> step == '0 && !step_pulse)
	else report_error($sformatf("step %0d or step pulse active while stopped", step));

	assert property (@(posedge clk) disable iff (!reset) mode == model_mode)
	else report_error($sformatf("mode %0d, expected %0d", mode, model_mode));

	assert property (@(posedge clk) disable iff (!reset) target == model_target)
	else report_error($sformatf("target %0d, expected %0d", target, model_target));

	always @(posedge clk) begin
		if (UUT.u_assertions.error_count != 0) begin
			abort_run("the bound port checker found a protocol violation");
		end
	end

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		abort_run("watchdog expired before the test sequence finished");
	end

	initial begin
		void'($urandom(SEED));
		reset = 1'b0;
		btn_mode = 1'b0;
		btn_next = 1'b0;
		btn_enter = 1'b0;
		sel = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b1;
		idle_cycles(2);

		press_button(KEY_ENTER); // start with empty patterns at the reset tempo
		wait_steps(seq_pkg::NUM_STEPS + 1);
		press_button(KEY_ENTER);
		idle_cycles(4);

		press_button(KEY_MODE); // edit voice, load all four voices
		for (int v = 0; v < seq_pkg::NUM_VOICES; v++) begin
			set_switches(8'($urandom()));
			press_button(KEY_ENTER);
			press_button(KEY_NEXT);
		end

		press_button(KEY_MODE); // edit tempo, then a zero word that must be ignored
		set_switches(8'(MIN_TEST_TEMPO + $urandom() % (256 - MIN_TEST_TEMPO)));
		press_button(KEY_ENTER);
		set_switches(8'd0);
		press_button(KEY_ENTER);

		press_button(KEY_MODE); // back in play mode, still stopped
		idle_cycles(4);
		press_button(KEY_ENTER);
		wait_steps(3 * seq_pkg::NUM_STEPS + 1);

		press_button(KEY_MODE); // leaving play while running stops the bar
		idle_cycles(6);
		press_button(KEY_MODE);
		press_button(KEY_MODE);
		idle_cycles(4);
		press_button(KEY_ENTER); // restart from step zero
		wait_steps(seq_pkg::NUM_STEPS + 1);
		press_button(KEY_ENTER);
		idle_cycles(4);
		@(negedge clk);

		if (UUT.u_assertions.error_count != 0) begin
			abort_run("the bound port checker found a protocol violation");
		end else begin
			$display("Testbench passed");
			$finish;
		end
	end

endmodule

/* compile.f */
src/tempo_pkg.sv
src/seq_pkg.sv
src/panel_control.sv
src/datapath.sv
src/beat_clock.sv
src/drum_machine.sv
tb/drum_machine_assertions.sv
tb/drum_machine_tb.sv

/* Bender.yml */
package:
  name: drum_machine

sources:
  - src/tempo_pkg.sv
  - src/seq_pkg.sv
  - src/panel_control.sv
  - src/datapath.sv
  - src/beat_clock.sv
  - src/drum_machine.sv
  - target: test
    files:
      - tb/drum_machine_assertions.sv
      - tb/drum_machine_tb.sv
